// ==== rtl/mm_pkg.sv ====
package mm_pkg;

  // Matrix and element sizes
  localparam int MM_SIZE   = 16;
  localparam int MM_DATA_W = 8;
  localparam int MM_ACC_W  = 20;
  localparam int MM_RES_W  = 16;

  // Memory bus sizes
  localparam int MM_ADDR_W = 64;
  localparam int MM_BUS_W  = MM_SIZE * MM_DATA_W;

  // Beat index must reach 2*SIZE
  localparam int MM_BEAT_W = $clog2(2 * MM_SIZE + 1);

  typedef logic [MM_ADDR_W-1:0]        gmem_addr_t;
  typedef logic [MM_BUS_W-1:0]         gmem_data_t;
  typedef logic signed [MM_ACC_W-1:0]  acc_t;
  typedef logic signed [MM_RES_W-1:0]  res_t;
  typedef logic [MM_BEAT_W-1:0]        beat_idx_t;

  // Job controller states
  typedef enum logic [3:0] {
    IDLE,
    RD_ACT_ADDR,
    RD_ACT_DATA,
    RD_WGT_ADDR,
    RD_WGT_DATA,
    COMPUTE,
    WR_ADDR,
    WR_DATA,
    WR_RESP,
    DONE
  } mm_state_e;

endpackage

// ==== rtl/mm_ctrl_fsm.sv ====
`timescale 1ns/1ps

module mm_ctrl_fsm #(
  parameter int SIZE = mm_pkg::MM_SIZE
) (
  input  logic                  ap_clk,
  input  logic                  ap_rst_n,
  input  logic                  start,
  input  mm_pkg::gmem_addr_t    act_base,
  input  mm_pkg::gmem_addr_t    wgt_base,
  input  mm_pkg::gmem_addr_t    out_base,
  input  logic                  arready,
  input  logic                  rvalid,
  input  logic                  rlast,
  input  logic                  awready,
  input  logic                  wready,
  input  logic                  bvalid,
  input  logic                  cnt_last,
  output logic                  arvalid,
  output mm_pkg::gmem_addr_t    araddr,
  output logic [7:0]            arlen,
  output logic                  rready,
  output logic                  awvalid,
  output mm_pkg::gmem_addr_t    awaddr,
  output logic [7:0]            awlen,
  output logic                  wvalid,
  output logic                  wlast,
  output logic                  bready,
  output logic                  cnt_clear,
  output logic                  cnt_inc,
  output mm_pkg::beat_idx_t     cnt_limit,
  output logic                  act_wr_en,
  output logic                  wgt_wr_en,
  output logic                  mac_en,
  output logic                  acc_clear,
  output logic                  busy,
  output logic                  done
);

  import mm_pkg::*;

  mm_state_e state;
  mm_state_e state_nxt;
  logic      rd_beat;
  logic      wr_beat;

  assign rd_beat = rready && rvalid;
  assign wr_beat = wvalid && wready;

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE:        if (start)             state_nxt = RD_ACT_ADDR;
      RD_ACT_ADDR: if (arready)           state_nxt = RD_ACT_DATA;
      RD_ACT_DATA: if (rd_beat && rlast)  state_nxt = RD_WGT_ADDR;
      RD_WGT_ADDR: if (arready)           state_nxt = RD_WGT_DATA;
      RD_WGT_DATA: if (rd_beat && rlast)  state_nxt = COMPUTE;
      COMPUTE:     if (cnt_last)          state_nxt = WR_ADDR;
      WR_ADDR:     if (awready)           state_nxt = WR_DATA;
      WR_DATA:     if (wr_beat && wlast)  state_nxt = WR_RESP;
      WR_RESP:     if (bvalid)            state_nxt = DONE;
      DONE:                               state_nxt = IDLE;
      default:                            state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      state     <= IDLE;
      mac_en    <= 1'b0;
      acc_clear <= 1'b0;
    end else begin
      state     <= state_nxt;
      // Buffer read takes one cycle, so the MAC enable trails the step by one
      mac_en    <= (state == COMPUTE) && !cnt_last;
      acc_clear <= (state == IDLE) && start;
    end
  end

  // Read channels
  assign arvalid = (state == RD_ACT_ADDR) || (state == RD_WGT_ADDR);
  assign araddr  = (state == RD_WGT_ADDR) ? wgt_base : act_base;
  assign arlen   = 8'(SIZE - 1);
  assign rready  = (state == RD_ACT_DATA) || (state == RD_WGT_DATA);

  // Operand buffer writes follow accepted beats
  assign act_wr_en = (state == RD_ACT_DATA) && rvalid;
  assign wgt_wr_en = (state == RD_WGT_DATA) && rvalid;

  // Write channels
  assign awvalid = (state == WR_ADDR);
  assign awaddr  = out_base;
  assign awlen   = 8'(2 * SIZE - 1);
  assign wvalid  = (state == WR_DATA);
  assign wlast   = (state == WR_DATA) && cnt_last;
  assign bready  = (state == WR_RESP);

  // Clear wins over inc at the end of each phase
  assign cnt_clear = (state == IDLE) || (state == DONE) || arvalid || awvalid
                  || (rd_beat && rlast)
                  || ((state == COMPUTE) && cnt_last)
                  || (wr_beat && wlast);
  assign cnt_inc   = rd_beat || (state == COMPUTE) || wr_beat;

  always_comb begin
    case (state)
      COMPUTE:                   cnt_limit = beat_idx_t'(SIZE);
      WR_ADDR, WR_DATA, WR_RESP: cnt_limit = beat_idx_t'(2 * SIZE - 1);
      default:                   cnt_limit = beat_idx_t'(SIZE - 1);
    endcase
  end

  assign busy = (state != IDLE);
  assign done = (state == DONE);

  // Write beat and its last flag must hold while the slave stalls
  assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
    wvalid && !wready |=> wvalid && $stable(wlast))
    else $error("write beat changed before wready");

endmodule

// ==== rtl/mm_beat_counter.sv ====
`timescale 1ns/1ps

module mm_beat_counter #(
  parameter int SIZE = mm_pkg::MM_SIZE
) (
  input  logic              ap_clk,
  input  logic              ap_rst_n,
  input  logic              clear,
  input  logic              inc,
  input  mm_pkg::beat_idx_t limit,
  output mm_pkg::beat_idx_t cnt,
  output logic              last
);

  import mm_pkg::*;

  always_ff @(posedge ap_clk) begin
    if (!ap_rst_n) begin
      cnt <= '0;
    end else if (clear) begin
      cnt <= '0;
    end else if (inc) begin
      cnt <= cnt + 1'b1;
    end
  end

  assign last = (cnt == limit);

  // Phase limits come from the controller and bound the count in every state
  assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
    (cnt <= limit) && (limit <= beat_idx_t'(2 * SIZE - 1)))
    else $error("beat count %0d beyond limit %0d", cnt, limit);

endmodule

// ==== rtl/mm_operand_buffer.sv ====
`timescale 1ns/1ps

module mm_operand_buffer #(
  parameter int SIZE = mm_pkg::MM_SIZE
) (
  input  logic                                ap_clk,
  input  logic                                wr_en,
  input  mm_pkg::beat_idx_t                   wr_addr,
  input  logic [SIZE*mm_pkg::MM_DATA_W-1:0]   wr_data,
  input  mm_pkg::beat_idx_t                   rd_addr,
  output logic [SIZE*mm_pkg::MM_DATA_W-1:0]   rd_data
);

  import mm_pkg::*;

  localparam int AW = (SIZE > 1) ? $clog2(SIZE) : 1;

  // One operand word per beat, SIZE beats per matrix
  logic [SIZE*MM_DATA_W-1:0] mem [SIZE];

  always_ff @(posedge ap_clk) begin
    if (wr_en) begin
      mem[wr_addr[AW-1:0]] <= wr_data;
    end
    rd_data <= mem[rd_addr[AW-1:0]];
  end

endmodule

// ==== rtl/mm_mac_array.sv ====
`timescale 1ns/1ps

module mm_mac_array #(
  parameter int SIZE = mm_pkg::MM_SIZE
) (
  input  logic                               ap_clk,
  input  logic                               ap_rst_n,
  input  logic                               acc_clear,
  input  logic                               mac_en,
  input  logic [SIZE*mm_pkg::MM_DATA_W-1:0]  act_word,
  input  logic [SIZE*mm_pkg::MM_DATA_W-1:0]  wgt_word,
  output mm_pkg::acc_t                       acc [SIZE*SIZE]
);

  import mm_pkg::*;

  // act_word holds column k of A, wgt_word holds row k of B
  for (genvar gi = 0; gi < SIZE; gi++) begin : g_row
    for (genvar gj = 0; gj < SIZE; gj++) begin : g_col
      logic signed [MM_DATA_W-1:0]   a_elem;
      logic signed [MM_DATA_W-1:0]   b_elem;
      logic signed [2*MM_DATA_W-1:0] prod;

      assign a_elem = act_word[gi*MM_DATA_W +: MM_DATA_W];
      assign b_elem = wgt_word[gj*MM_DATA_W +: MM_DATA_W];
      assign prod   = a_elem * b_elem;

      always_ff @(posedge ap_clk) begin
        if (!ap_rst_n || acc_clear) begin
          acc[gi*SIZE+gj] <= '0;
        end else if (mac_en) begin
          // Outer product term, sign extended into the accumulator
          acc[gi*SIZE+gj] <= acc[gi*SIZE+gj] + prod;
        end
      end
    end
  end

  // Clear only comes at job start, well before any compute step
  assert property (@(posedge ap_clk) disable iff (!ap_rst_n)
    !(acc_clear && mac_en))
    else $error("accumulator clear overlaps a MAC step");

endmodule

// ==== rtl/mm_result_packer.sv ====
`timescale 1ns/1ps

module mm_result_packer #(
  parameter int SIZE = mm_pkg::MM_SIZE
) (
  input  mm_pkg::acc_t                       acc [SIZE*SIZE],
  input  mm_pkg::beat_idx_t                  beat,
  output logic [SIZE*mm_pkg::MM_DATA_W-1:0]  wdata
);

  import mm_pkg::*;

  localparam int HALF = SIZE / 2;

  // Clamp to the INT16 range
  function automatic res_t sat_res(input acc_t a);
    logic [MM_ACC_W-MM_RES_W:0] top;
    top = a[MM_ACC_W-1:MM_RES_W-1];
    if (top == '0 || top == '1) begin
      return a[MM_RES_W-1:0];
    end else if (a[MM_ACC_W-1]) begin
      return {1'b1, {(MM_RES_W-1){1'b0}}};
    end else begin
      return {1'b0, {(MM_RES_W-1){1'b1}}};
    end
  endfunction

  // Even beat is the left half of a row, odd beat the right half
  always_comb begin
    int row;
    int col;
    row = int'(beat) / 2;
    for (int c = 0; c < HALF; c++) begin
      col = int'(beat[0]) * HALF + c;
      wdata[c*MM_RES_W +: MM_RES_W] = sat_res(acc[row*SIZE+col]);
    end
  end

endmodule

// ==== rtl/mm_top.sv ====
`timescale 1ns/1ps

module mm_top #(
  parameter int SIZE = mm_pkg::MM_SIZE
) (
  input  logic                               ap_clk,
  input  logic                               ap_rst_n,
  input  logic                               start,
  input  mm_pkg::gmem_addr_t                 act_base,
  input  mm_pkg::gmem_addr_t                 wgt_base,
  input  mm_pkg::gmem_addr_t                 out_base,
  output logic                               busy,
  output logic                               done,
  output logic                               arvalid,
  input  logic                               arready,
  output mm_pkg::gmem_addr_t                 araddr,
  output logic [7:0]                         arlen,
  input  logic                               rvalid,
  output logic                               rready,
  input  logic [SIZE*mm_pkg::MM_DATA_W-1:0]  rdata,
  input  logic                               rlast,
  output logic                               awvalid,
  input  logic                               awready,
  output mm_pkg::gmem_addr_t                 awaddr,
  output logic [7:0]                         awlen,
  output logic                               wvalid,
  input  logic                               wready,
  output logic [SIZE*mm_pkg::MM_DATA_W-1:0]  wdata,
  output logic                               wlast,
  input  logic                               bvalid,
  output logic                               bready
);

  import mm_pkg::*;

  logic                      cnt_clear;
  logic                      cnt_inc;
  beat_idx_t                 cnt_limit;
  beat_idx_t                 cnt;
  logic                      cnt_last;
  logic                      act_wr_en;
  logic                      wgt_wr_en;
  logic                      mac_en;
  logic                      acc_clear;
  logic [SIZE*MM_DATA_W-1:0] act_word;
  logic [SIZE*MM_DATA_W-1:0] wgt_word;
  acc_t                      acc [SIZE*SIZE];

  mm_ctrl_fsm #(.SIZE(SIZE)) ctrl0 (
    .ap_clk    (ap_clk),
    .ap_rst_n  (ap_rst_n),
    .start     (start),
    .act_base  (act_base),
    .wgt_base  (wgt_base),
    .out_base  (out_base),
    .arready   (arready),
    .rvalid    (rvalid),
    .rlast     (rlast),
    .awready   (awready),
    .wready    (wready),
    .bvalid    (bvalid),
    .cnt_last  (cnt_last),
    .arvalid   (arvalid),
    .araddr    (araddr),
    .arlen     (arlen),
    .rready    (rready),
    .awvalid   (awvalid),
    .awaddr    (awaddr),
    .awlen     (awlen),
    .wvalid    (wvalid),
    .wlast     (wlast),
    .bready    (bready),
    .cnt_clear (cnt_clear),
    .cnt_inc   (cnt_inc),
    .cnt_limit (cnt_limit),
    .act_wr_en (act_wr_en),
    .wgt_wr_en (wgt_wr_en),
    .mac_en    (mac_en),
    .acc_clear (acc_clear),
    .busy      (busy),
    .done      (done)
  );

  mm_beat_counter #(.SIZE(SIZE)) cnt0 (
    .ap_clk   (ap_clk),
    .ap_rst_n (ap_rst_n),
    .clear    (cnt_clear),
    .inc      (cnt_inc),
    .limit    (cnt_limit),
    .cnt      (cnt),
    .last     (cnt_last)
  );

  // Same count addresses the write during reads and the read during compute
  mm_operand_buffer #(.SIZE(SIZE)) act_buf (
    .ap_clk  (ap_clk),
    .wr_en   (act_wr_en),
    .wr_addr (cnt),
    .wr_data (rdata),
    .rd_addr (cnt),
    .rd_data (act_word)
  );

  mm_operand_buffer #(.SIZE(SIZE)) wgt_buf (
    .ap_clk  (ap_clk),
    .wr_en   (wgt_wr_en),
    .wr_addr (cnt),
    .wr_data (rdata),
    .rd_addr (cnt),
    .rd_data (wgt_word)
  );

  mm_mac_array #(.SIZE(SIZE)) mac0 (
    .ap_clk    (ap_clk),
    .ap_rst_n  (ap_rst_n),
    .acc_clear (acc_clear),
    .mac_en    (mac_en),
    .act_word  (act_word),
    .wgt_word  (wgt_word),
    .acc       (acc)
  );

  mm_result_packer #(.SIZE(SIZE)) pack0 (
    .acc   (acc),
    .beat  (cnt),
    .wdata (wdata)
  );

endmodule

// ==== test/tb_gmem_model.sv ====
`timescale 1ns/1ps

module tb_gmem_model #(
  parameter int SIZE = mm_pkg::MM_SIZE
) (
  input  logic                               ap_clk,
  input  logic [4:0]                         stall,
  input  logic                               log_clear,
  input  logic                               arvalid,
  output logic                               arready,
  input  mm_pkg::gmem_addr_t                 araddr,
  input  logic [7:0]                         arlen,
  output logic                               rvalid,
  input  logic                               rready,
  output logic [SIZE*mm_pkg::MM_DATA_W-1:0]  rdata,
  output logic                               rlast,
  input  logic                               awvalid,
  output logic                               awready,
  input  mm_pkg::gmem_addr_t                 awaddr,
  input  logic [7:0]                         awlen,
  input  logic                               wvalid,
  output logic                               wready,
  input  logic [SIZE*mm_pkg::MM_DATA_W-1:0]  wdata,
  input  logic                               wlast,
  output logic                               bvalid,
  input  logic                               bready
);

  import mm_pkg::*;

  localparam int BYTES     = SIZE * MM_DATA_W / 8;
  localparam int MEM_WORDS = 256;
  localparam int LOG_MAX   = 64;

  logic [SIZE*MM_DATA_W-1:0] mem [MEM_WORDS];
  gmem_addr_t                ar_addr_log [4];
  logic [7:0]                ar_len_log [4];
  gmem_addr_t                aw_addr_log;
  logic [7:0]                aw_len_log;
  logic [SIZE*MM_DATA_W-1:0] wlog_data [LOG_MAX];
  logic                      wlog_last [LOG_MAX];
  int                        ar_cnt;
  int                        aw_cnt;
  int                        w_cnt;
  int                        rd_word;
  int                        rd_left;
  logic                      b_pending;
  logic                      r_fire;
  logic                      b_fire;
  logic [4:0]                stall_s;

  initial begin
    {arready, rvalid, rlast, awready, wready, bvalid} = '0;
    rdata     = '0;
    ar_cnt    = 0;
    aw_cnt    = 0;
    w_cnt     = 0;
    rd_word   = 0;
    rd_left   = 0;
    b_pending = 1'b0;
    forever begin
      // Sample at mid-cycle, where every DUT output has settled
      @(negedge ap_clk);
      stall_s = stall;
      r_fire  = rvalid && rready;
      b_fire  = bvalid && bready;
      if (log_clear) begin
        ar_cnt = 0;
        aw_cnt = 0;
        w_cnt  = 0;
      end
      if (arvalid && arready) begin
        if (ar_cnt < 4) begin
          ar_addr_log[ar_cnt] = araddr;
          ar_len_log[ar_cnt]  = arlen;
        end
        ar_cnt++;
        rd_word = int'((araddr / 64'(BYTES)) % 64'(MEM_WORDS));
        rd_left = int'(arlen) + 1;
      end
      if (r_fire) begin
        rd_word = (rd_word + 1) % MEM_WORDS;
        rd_left--;
      end
      if (awvalid && awready) begin
        aw_addr_log = awaddr;
        aw_len_log  = awlen;
        aw_cnt++;
      end
      if (wvalid && wready) begin
        if (w_cnt < LOG_MAX) begin
          wlog_data[w_cnt] = wdata;
          wlog_last[w_cnt] = wlast;
        end
        w_cnt++;
        b_pending = b_pending || wlast;
      end
      if (b_fire) begin
        b_pending = 1'b0;
      end
      @(posedge ap_clk);
      #1;
      arready = !stall_s[0];
      awready = !stall_s[2];
      wready  = !stall_s[3];
      // A raised valid stays up until its beat is taken
      if (!rvalid || r_fire) begin
        rvalid = (rd_left > 0) && !stall_s[1];
      end
      rdata = mem[rd_word];
      rlast = (rd_left == 1);
      if (!bvalid || b_fire) begin
        bvalid = b_pending && !stall_s[4];
      end
    end
  end

endmodule

// ==== test/tb_mm_top.sv ====
`timescale 1ns/1ps

module tb_mm_top;

  import mm_pkg::*;

  localparam int SIZE        = 16;
  localparam int BUS_W       = SIZE * MM_DATA_W;
  localparam int CYCLE_LIMIT = 8 * 400;

  logic             ap_clk;
  logic             ap_rst_n;
  logic             start;
  gmem_addr_t       act_base;
  gmem_addr_t       wgt_base;
  gmem_addr_t       out_base;
  logic             busy;
  logic             done;
  logic             arvalid;
  logic             arready;
  gmem_addr_t       araddr;
  logic [7:0]       arlen;
  logic             rvalid;
  logic             rready;
  logic [BUS_W-1:0] rdata;
  logic             rlast;
  logic             awvalid;
  logic             awready;
  gmem_addr_t       awaddr;
  logic [7:0]       awlen;
  logic             wvalid;
  logic             wready;
  logic [BUS_W-1:0] wdata;
  logic             wlast;
  logic             bvalid;
  logic             bready;
  logic [4:0]       stall;
  logic             stall_on;
  logic             log_clear;
  logic [31:0]      data_seed;
  logic [31:0]      stall_seed;
  int               errors;
  int               tests_run;
  int               tests_failed;
  int               cycles = 0;
  int               mat_a [SIZE][SIZE];
  int               mat_b [SIZE][SIZE];

  mm_top #(.SIZE(SIZE)) dut0 (.*);

  tb_gmem_model #(.SIZE(SIZE)) mem0 (.*);

  initial begin
    ap_clk = 1'b0;
    forever #50 ap_clk = ~ap_clk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Each channel stalls about one cycle in four when enabled
  always @(posedge ap_clk) begin
    #1;
    stall_seed = lcg_next(stall_seed);
    for (int c = 0; c < 5; c++) begin
      stall[c] = stall_on && (stall_seed[20+2*c +: 2] == 2'b00);
    end
  end

  always @(posedge ap_clk) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("Timeout: the jobs did not finish within %0d cycles", CYCLE_LIMIT);
      $display("TB FAILED");
      $finish;
    end
  end

  task automatic check_val(input string name, input logic [127:0] got,
                           input logic [127:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      errors++;
    end
  endtask

  function automatic logic [15:0] sat16(input int v);
    if (v > 32767) return 16'h7fff;
    if (v < -32768) return 16'h8000;
    return 16'(v);
  endfunction

  // Beat 2i holds the left half of row i, beat 2i+1 the right half
  function automatic logic [BUS_W-1:0] expected_beat(input int b);
    logic [BUS_W-1:0] w;
    int               sum;
    w = '0;
    for (int c = 0; c < SIZE / 2; c++) begin
      sum = 0;
      for (int k = 0; k < SIZE; k++) begin
        sum += mat_a[b/2][k] * mat_b[k][(b % 2) * (SIZE / 2) + c];
      end
      w[c*16 +: 16] = sat16(sum);
    end
    return w;
  endfunction

  // Mode 0 random, mode 1 all -128 by -128, mode 2 all -128 by 127
  task automatic fill_mats(input int mode);
    for (int i = 0; i < SIZE; i++) begin
      for (int j = 0; j < SIZE; j++) begin
        data_seed = lcg_next(data_seed);
        mat_a[i][j] = (mode == 0) ? int'($signed(data_seed[23:16])) : -128;
        data_seed = lcg_next(data_seed);
        mat_b[i][j] = (mode == 0) ? int'($signed(data_seed[23:16])) :
                      (mode == 1) ? -128 : 127;
      end
    end
  endtask

  task automatic run_job(input string name, input int mode, input logic with_stall,
                         input logic extra_start);
    logic [BUS_W-1:0] word_a;
    logic [BUS_W-1:0] word_b;
    int               act_idx;
    int               wgt_idx;
    int               done_cnt;
    int               waited;
    int               err0;
    err0 = errors;
    fill_mats(mode);
    data_seed = lcg_next(data_seed);
    act_idx = int'(data_seed[21:16]) % 48;
    wgt_idx = 64 + int'(data_seed[29:24]) % 48;
    // Activation word k is column k of A, weight word k is row k of B
    for (int k = 0; k < SIZE; k++) begin
      for (int n = 0; n < SIZE; n++) begin
        word_a[n*8 +: 8] = 8'(mat_a[n][k]);
        word_b[n*8 +: 8] = 8'(mat_b[k][n]);
      end
      mem0.mem[act_idx + k] = word_a;
      mem0.mem[wgt_idx + k] = word_b;
    end
    @(negedge ap_clk);
    stall_on = with_stall;
    @(posedge ap_clk);
    #1;
    act_base  = {data_seed, 20'h0, 12'(act_idx * 16)};
    wgt_base  = {~data_seed, 20'h0, 12'(wgt_idx * 16)};
    out_base  = {data_seed ^ 32'h5a5a_0000, 20'h0, 12'h800};
    log_clear = 1'b1;
    start     = 1'b1;
    @(posedge ap_clk);
    #1;
    log_clear = 1'b0;
    start     = 1'b0;
    done_cnt  = 0;
    waited    = 0;
    while (done_cnt == 0) begin
      @(negedge ap_clk);
      if (!busy) begin
        $display("Busy dropped before done in test %s", name);
        errors++;
      end
      if (done) done_cnt++;
      waited++;
      // A second start while busy must be ignored
      if (extra_start && waited == 6) begin
        @(posedge ap_clk);
        #1;
        start = 1'b1;
        @(posedge ap_clk);
        #1;
        start = 1'b0;
      end
    end
    repeat (3) begin
      @(negedge ap_clk);
      if (done) done_cnt++;
    end
    check_val("done pulses", 128'(done_cnt), 128'(1));
    check_val("busy", 128'(busy), 128'(0));
    check_val("read bursts", 128'(mem0.ar_cnt), 128'(2));
    check_val("araddr act", 128'(mem0.ar_addr_log[0]), 128'(act_base));
    check_val("arlen act", 128'(mem0.ar_len_log[0]), 128'(SIZE - 1));
    check_val("araddr wgt", 128'(mem0.ar_addr_log[1]), 128'(wgt_base));
    check_val("arlen wgt", 128'(mem0.ar_len_log[1]), 128'(SIZE - 1));
    check_val("write bursts", 128'(mem0.aw_cnt), 128'(1));
    check_val("awaddr", 128'(mem0.aw_addr_log), 128'(out_base));
    check_val("awlen", 128'(mem0.aw_len_log), 128'(2 * SIZE - 1));
    check_val("write beats", 128'(mem0.w_cnt), 128'(2 * SIZE));
    for (int b = 0; b < 2 * SIZE; b++) begin
      check_val($sformatf("wdata[%0d]", b), 128'(mem0.wlog_data[b]), 128'(expected_beat(b)));
      check_val($sformatf("wlast[%0d]", b), 128'(mem0.wlog_last[b]), 128'(b == 2 * SIZE - 1));
    end
    tests_run++;
    if (errors == err0) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d mismatches", name, errors - err0);
      tests_failed++;
    end
  endtask

  initial begin
    ap_rst_n     = 1'b0;
    start        = 1'b0;
    act_base     = '0;
    wgt_base     = '0;
    out_base     = '0;
    stall        = '0;
    stall_on     = 1'b0;
    log_clear    = 1'b0;
    data_seed    = 32'd79328;
    stall_seed   = ~32'd79328;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (4) @(posedge ap_clk);
    #1;
    ap_rst_n = 1'b1;
    run_job("random product", 0, 1'b0, 1'b0);
    run_job("saturation high", 1, 1'b0, 1'b0);
    run_job("saturation low", 2, 1'b0, 1'b0);
    run_job("back-pressure", 0, 1'b1, 1'b0);
    run_job("burst framing", 0, 1'b1, 1'b0);
    run_job("control", 0, 1'b0, 1'b1);
    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
rtl/mm_pkg.sv
rtl/mm_ctrl_fsm.sv
rtl/mm_beat_counter.sv
rtl/mm_operand_buffer.sv
rtl/mm_mac_array.sv
rtl/mm_result_packer.sv
rtl/mm_top.sv
test/tb_gmem_model.sv
test/tb_mm_top.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_mm_top
FILELIST = compile.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qx "TB PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
